/* logic/arrayPkg.sv */
// Array memory shared definitions
// Sizes, element types, opcode and error enums

package arrayPkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int arrayBits   = 2;                 // Array number width
  localparam int arrays      = 4;                 // Number of arrays
  localparam int indexBits   = 3;                 // Element index width
  localparam int arrayLength = 8;                 // Elements per array
  localparam int dataBits    = 12;                // Element width

  // ----------------------------------------
  // Field types
  // ----------------------------------------
  typedef logic [arrayBits-1:0] arrayNumber;      // Selects one array
  typedef logic [indexBits-1:0] elementIndex;     // Selects one element
  typedef logic [indexBits:0]   arraySize;        // One extra bit so it can hold 8
  typedef logic [dataBits-1:0]  dataWord;         // Element contents

  // ----------------------------------------
  // Commands
  // ----------------------------------------
  typedef enum logic [3:0] {
    opWrite = 4'd0,                               // Store operand at index
    opRead  = 4'd1,                               // Return element at index
    opSize  = 4'd2,                               // Return current size
    opPush  = 4'd3,                               // Append operand
    opPop   = 4'd4,                               // Remove and return last element
    opAlloc = 4'd5,                               // Claim lowest free array
    opFree  = 4'd6,                               // Release an array
    opAdd   = 4'd7,                               // Element plus operand
    opXor   = 4'd8                                // Element xor operand
  } opcode;

  // ----------------------------------------
  // Errors
  // ----------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                       // Array was never allocated or was freed
    errOutOfBounds  = 3'd2,                       // Index at or beyond size
    errFull         = 3'd3,                       // Push to a full array
    errEmpty        = 3'd4,                       // Pop from an empty array
    errNoMemory     = 3'd5                        // All arrays in use
  } errorCode;

endpackage

/* logic/decodedIf.sv */
// Checked command from decode to execute
// Index already resolved, error already known

interface decodedIf import arrayPkg::*; ();

  logic        valid;                             // Command present this cycle
  opcode       op;
  arrayNumber  array;
  elementIndex index;                             // Resolved element
  dataWord     operand;                           // Data from the command
  errorCode    error;                             // errNone when legal
  dataWord     value;                             // Allocated array or size

  modport source (
    output valid, op, array, index, operand, error, value
  );

  modport sink (
    input valid, op, array, index, operand, error, value
  );

endinterface

/* logic/executedIf.sv */
// Element values and status from execute to result

interface executedIf import arrayPkg::*; ();

  logic     valid;                                // Command present this cycle
  opcode    op;
  errorCode error;
  dataWord  oldValue;                             // Element before the command
  dataWord  newValue;                             // Element after the command
  dataWord  value;                                // Passed on from decode

  modport source (
    output valid, op, error, oldValue, newValue, value
  );

  modport sink (
    input valid, op, error, oldValue, newValue, value
  );

endinterface

/* logic/commandDecode.sv */
// Command decode stage
// Allocation flags, size table, legality checks, index resolution

module commandDecode import arrayPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cmdValid,
  input  opcode       cmdOp,
  input  arrayNumber  cmdArray,
  input  elementIndex cmdIndex,
  input  dataWord     cmdData,
  decodedIf.source    decoded
);

  logic [arrays-1:0]    allocated;                // One flag per array
  arraySize [arrays-1:0] sizes;                   // Current size per array

  arraySize    curSize;
  arraySize    indexSize;                         // cmdIndex widened for compares
  arrayNumber  freeArray;                         // Lowest unallocated array
  errorCode    checkError;
  elementIndex resolvedIndex;
  dataWord     resolvedValue;

  // ----------------------------------------
  // Checks and resolution
  // ----------------------------------------
  always_comb begin
    curSize   = sizes[cmdArray];
    indexSize = arraySize'(cmdIndex);
    freeArray = '0;
    for (int i = arrays - 1; i >= 0; i--) begin
      if (!allocated[i]) freeArray = arrayNumber'(i);   // Last hit is the lowest
    end

    checkError = errNone;
    if (cmdOp == opAlloc) begin
      if (&allocated) checkError = errNoMemory;
    end else if (!allocated[cmdArray]) begin
      checkError = errNotAllocated;
    end else begin
      case (cmdOp)
        opRead, opAdd, opXor: if (indexSize >= curSize) checkError = errOutOfBounds;
        opPush: if (curSize == arraySize'(arrayLength)) checkError = errFull;
        opPop:  if (curSize == '0) checkError = errEmpty;
        default: ;
      endcase
    end

    case (cmdOp)
      opPush:  resolvedIndex = curSize[indexBits-1:0];        // Next free slot
      opPop:   resolvedIndex = elementIndex'(curSize - 1'b1); // Top of stack
      default: resolvedIndex = cmdIndex;
    endcase

    case (cmdOp)
      opAlloc: resolvedValue = dataWord'(freeArray);
      opSize:  resolvedValue = dataWord'(curSize);
      default: resolvedValue = '0;
    endcase
  end

  // ----------------------------------------
  // Allocation and size tables
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated     <= '0;
      sizes         <= '0;
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= cmdValid;
      if (cmdValid && checkError == errNone) begin
        case (cmdOp)
          opWrite: if (indexSize >= curSize) sizes[cmdArray] <= indexSize + 1'b1;
          opPush:  sizes[cmdArray] <= curSize + 1'b1;
          opPop:   sizes[cmdArray] <= curSize - 1'b1;
          opAlloc: begin
            allocated[freeArray] <= 1'b1;
            sizes[freeArray]     <= '0;               // New array starts empty
          end
          opFree:  allocated[cmdArray] <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin                  // Command payload
    decoded.op      <= cmdOp;
    decoded.array   <= cmdArray;
    decoded.index   <= resolvedIndex;
    decoded.operand <= cmdData;
    decoded.error   <= checkError;
    decoded.value   <= resolvedValue;
  end

endmodule

/* logic/elementExecute.sv */
// Execute stage
// Element store with read-modify-write for write, push, add and xor

module elementExecute import arrayPkg::*; (
  input  logic      clock,
  input  logic      reset,
  decodedIf.sink    decoded,
  executedIf.source executed
);

  dataWord store [arrays][arrayLength];           // 4 by 8 elements

  dataWord oldValue;
  dataWord newValue;
  logic    writeEnable;

  // ----------------------------------------
  // Element update
  // ----------------------------------------
  always_comb begin
    oldValue    = store[decoded.array][decoded.index];
    newValue    = oldValue;
    writeEnable = 1'b0;
    if (decoded.valid && decoded.error == errNone) begin
      case (decoded.op)
        opWrite, opPush: begin
          newValue    = decoded.operand;
          writeEnable = 1'b1;
        end
        opAdd: begin
          newValue    = oldValue + decoded.operand;   // Wraps at 12 bits
          writeEnable = 1'b1;
        end
        opXor: begin
          newValue    = oldValue ^ decoded.operand;
          writeEnable = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (writeEnable) store[decoded.array][decoded.index] <= newValue;
  end

  // ----------------------------------------
  // Stage registers
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      executed.valid <= 1'b0;
    end else begin
      executed.valid <= decoded.valid;
    end
  end

  always_ff @(posedge clock) begin
    executed.op       <= decoded.op;
    executed.error    <= decoded.error;
    executed.oldValue <= oldValue;
    executed.newValue <= newValue;
    executed.value    <= decoded.value;
  end

endmodule

/* logic/resultSelect.sv */
// Result stage
// Picks the returned value per opcode and registers the outputs

module resultSelect import arrayPkg::*; (
  input  logic     clock,
  input  logic     reset,
  executedIf.sink  executed,
  output logic     resultValid,
  output dataWord  resultData,
  output errorCode resultError
);

  dataWord selected;

  always_comb begin
    selected = '0;                                // Push, free and errors return zero
    if (executed.error == errNone) begin
      case (executed.op)
        opRead, opPop:         selected = executed.oldValue;
        opWrite, opAdd, opXor: selected = executed.newValue;
        opSize, opAlloc:       selected = executed.value;
        default:               selected = '0;
      endcase
    end
  end

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      resultValid <= 1'b0;
      resultData  <= '0;
      resultError <= errNone;
    end else begin
      resultValid <= executed.valid;
      if (executed.valid) begin                   // Hold last result between commands
        resultData  <= selected;
        resultError <= executed.error;
      end
    end
  end

endmodule

/* logic/arrayMemory.sv */
// Array memory top level
// Decode, execute and result stages on plain ports

module arrayMemory import arrayPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cmdValid,                   // One-cycle command strobe
  input  opcode       cmdOp,
  input  arrayNumber  cmdArray,
  input  elementIndex cmdIndex,
  input  dataWord     cmdData,
  output logic        resultValid,                // Three cycles after cmdValid
  output dataWord     resultData,
  output errorCode    resultError
);

  decodedIf  decodedBus ();
  executedIf executedBus ();

  commandDecode i_commandDecode (
    .clock    (clock),
    .reset    (reset),
    .cmdValid (cmdValid),
    .cmdOp    (cmdOp),
    .cmdArray (cmdArray),
    .cmdIndex (cmdIndex),
    .cmdData  (cmdData),
    .decoded  (decodedBus.source)
  );

  elementExecute i_elementExecute (
    .clock    (clock),
    .reset    (reset),
    .decoded  (decodedBus.sink),
    .executed (executedBus.source)
  );

  resultSelect i_resultSelect (
    .clock       (clock),
    .reset       (reset),
    .executed    (executedBus.sink),
    .resultValid (resultValid),
    .resultData  (resultData),
    .resultError (resultError)
  );

endmodule

/* testbench/arrayMemoryAssertions.sv */
// Concurrent checks on the array memory ports
// Latency, reset state and zero data on errors

module arrayMemoryAssertions import arrayPkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     cmdValid,
  input logic     resultValid,
  input dataWord  resultData,
  input errorCode resultError
);

  // ----------------------------------------
  // Three-stage latency
  // ----------------------------------------
  resultFollowsCommand: assert property (
    @(posedge clock) disable iff (!reset) cmdValid |-> ##3 resultValid
  ) else $error("resultValid missing three cycles after cmdValid");

  commandBeforeResult: assert property (
    @(posedge clock) disable iff (!reset) resultValid |-> $past(cmdValid, 3)
  ) else $error("resultValid without a command three cycles earlier");

  quietInReset: assert property (
    @(posedge clock) !reset |-> !resultValid
  ) else $error("resultValid high while reset is held");

  zeroDataOnError: assert property (
    @(posedge clock) disable iff (!reset) (resultError != errNone) |-> (resultData == '0)
  ) else $error("resultData not zero on an error result");

endmodule

bind arrayMemory arrayMemoryAssertions i_arrayMemoryAssertions (
  .clock       (clock),
  .reset       (reset),
  .cmdValid    (cmdValid),
  .resultValid (resultValid),
  .resultData  (resultData),
  .resultError (resultError)
);

/* testbench/arrayMemoryTb.sv */
// Array memory testbench
// Clock, reset, directed and random stimulus, reference model, result compare, watchdog

module arrayMemoryTb import arrayPkg::*; ();

  localparam int directedCommands = 120;          // Upper bound on directed commands
  localparam int randomCommands   = 300;
  localparam int totalCommands    = directedCommands + randomCommands;

  logic        clock;
  logic        reset;
  logic        cmdValid;
  opcode       cmdOp;
  arrayNumber  cmdArray;
  elementIndex cmdIndex;
  dataWord     cmdData;
  logic        resultValid;
  dataWord     resultData;
  errorCode    resultError;

  integer   seed;
  int       errorCount;
  int       resultCount;
  int       expectedData [$];
  errorCode expectedError [$];

  // Reference state
  logic modelAllocated [arrays];
  int   modelSize [arrays];
  int   modelStore [arrays][arrayLength];

  arrayMemory i_arrayMemory (
    .clock       (clock),
    .reset       (reset),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .cmdArray    (cmdArray),
    .cmdIndex    (cmdIndex),
    .cmdData     (cmdData),
    .resultValid (resultValid),
    .resultData  (resultData),
    .resultError (resultError)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic void referenceModel(input opcode op, input int arr, input int idx,
                                         input int data, output int expData,
                                         output errorCode expError);
    int freeArray;
    expData   = 0;
    expError  = errNone;
    freeArray = -1;
    for (int i = 0; i < arrays; i++) begin
      if (!modelAllocated[i] && freeArray < 0) freeArray = i;     // Lowest free wins
    end
    if (op == opAlloc) begin
      if (freeArray < 0) begin
        expError = errNoMemory;
      end else begin
        modelAllocated[freeArray] = 1'b1;
        modelSize[freeArray]      = 0;
        expData                   = freeArray;
      end
    end else if (!modelAllocated[arr]) begin
      expError = errNotAllocated;
    end else begin
      case (op)
        opWrite: begin
          modelStore[arr][idx] = data;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;   // Write grows the array
          expData = data;
        end
        opRead: begin
          if (idx >= modelSize[arr]) expError = errOutOfBounds;
          else expData = modelStore[arr][idx];
        end
        opSize: expData = modelSize[arr];
        opPush: begin
          if (modelSize[arr] == arrayLength) begin
            expError = errFull;
          end else begin
            modelStore[arr][modelSize[arr]] = data;
            modelSize[arr]++;
          end
        end
        opPop: begin
          if (modelSize[arr] == 0) begin
            expError = errEmpty;
          end else begin
            modelSize[arr]--;
            expData = modelStore[arr][modelSize[arr]];
          end
        end
        opFree: modelAllocated[arr] = 1'b0;
        opAdd, opXor: begin
          if (idx >= modelSize[arr]) begin
            expError = errOutOfBounds;
          end else begin
            if (op == opAdd) modelStore[arr][idx] = (modelStore[arr][idx] + data) % 4096;
            else modelStore[arr][idx] = modelStore[arr][idx] ^ data;
            expData = modelStore[arr][idx];
          end
        end
        default: ;
      endcase
    end
  endfunction

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic issueCommand(input opcode op, input int arr, input int idx, input int data);
    int       expData;
    errorCode expError;
    @(negedge clock);
    cmdValid = 1'b1;
    cmdOp    = op;
    cmdArray = arrayNumber'(arr);
    cmdIndex = elementIndex'(idx);
    cmdData  = dataWord'(data);
    referenceModel(op, arr, idx, data, expData, expError);
    expectedData.push_back(expData);
    expectedError.push_back(expError);
  endtask

  task automatic stopCommands();
    @(negedge clock);
    cmdValid = 1'b0;
  endtask

  function automatic int randomWord();
    return $unsigned($random(seed)) % 4096;
  endfunction

  // Mostly element operations, now and then alloc or free
  function automatic opcode pickOperation(input int r);
    case (r)
      0, 1, 2, 3: return opWrite;
      4, 5, 19:   return opRead;
      6:          return opSize;
      7, 8, 9:    return opPush;
      10, 11, 12: return opPop;
      13, 14:     return opAdd;
      15, 16:     return opXor;
      17:         return opAlloc;
      default:    return opFree;
    endcase
  endfunction

  task automatic checkValue(input string label, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail at time %0t: %s expected %0h, got %0h", $time, label, expected, actual);
    end
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(negedge clock) begin
    if (reset && resultValid) begin
      if (expectedData.size() == 0) begin
        errorCount++;
        $display("Error at time %0t: a result came out with no command pending", $time);
      end else begin
        resultCount++;
        checkValue($sformatf("result %0d data", resultCount), 32'(resultData),
                   32'(expectedData.pop_front()));
        checkValue($sformatf("result %0d error", resultCount), 32'(resultError),
                   32'(expectedError.pop_front()));
      end
    end
  end

  // One cycle per command plus 200 cycles of margin
  initial begin
    #(totalCommands * 20 + 200 * 20);
    $display("Watchdog: the run timed out before all results came back");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int arr;
    int idx;
    seed        = 21;
    errorCount  = 0;
    resultCount = 0;
    reset       = 1'b0;
    cmdValid    = 1'b0;
    cmdOp       = opRead;
    cmdArray    = '0;
    cmdIndex    = '0;
    cmdData     = '0;
    for (int a = 0; a < arrays; a++) begin
      modelAllocated[a] = 1'b0;
      modelSize[a]      = 0;
    end
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    repeat (5) issueCommand(opAlloc, 0, 0, 0);                  // Fifth finds no memory
    issueCommand(opFree, 2, 0, 0);
    issueCommand(opAlloc, 0, 0, 0);
    issueCommand(opFree, 2, 0, 0);
    issueCommand(opFree, 2, 0, 0);                              // Double free
    issueCommand(opAlloc, 0, 0, 0);

    for (int a = 0; a < arrays; a++) begin                      // Fill every element once
      for (int i = 0; i < arrayLength; i++) issueCommand(opWrite, a, i, randomWord());
    end

    issueCommand(opFree, 1, 0, 0);
    issueCommand(opAlloc, 0, 0, 0);
    repeat (4) issueCommand(opWrite, 1, $unsigned($random(seed)) % 6, randomWord());
    issueCommand(opSize, 1, 0, 0);
    for (int i = 0; i < arrayLength; i++) issueCommand(opRead, 1, i, 0);

    issueCommand(opFree, 1, 0, 0);
    issueCommand(opAlloc, 0, 0, 0);
    repeat (9) issueCommand(opPush, 1, 0, randomWord());       // Last one is full
    issueCommand(opSize, 1, 0, 0);
    repeat (9) issueCommand(opPop, 1, 0, 0);                    // Last one is empty

    issueCommand(opAdd, 0, 3, 12'hfff);
    issueCommand(opAdd, 0, 3, 12'h801);
    issueCommand(opXor, 0, 3, 12'ha5a);
    issueCommand(opRead, 0, 3, 0);
    issueCommand(opXor, 0, 7, randomWord());
    issueCommand(opAdd, 0, 7, randomWord());
    issueCommand(opRead, 0, 7, 0);

    arr = 0;
    idx = 0;
    for (int n = 0; n < randomCommands; n++) begin
      if ($random(seed) & 1) begin                              // Else reuse the same element
        arr = $unsigned($random(seed)) % arrays;
        idx = $unsigned($random(seed)) % arrayLength;
      end
      issueCommand(pickOperation($unsigned($random(seed)) % 20), arr, idx, randomWord());
    end

    issueCommand(opFree, 3, 0, 0);
    issueCommand(opFree, 3, 0, 0);
    issueCommand(opWrite, 3, 1, randomWord());
    issueCommand(opRead, 3, 1, 0);
    issueCommand(opSize, 3, 0, 0);
    issueCommand(opPush, 3, 0, randomWord());
    issueCommand(opPop, 3, 0, 0);
    issueCommand(opAdd, 3, 1, randomWord());
    issueCommand(opXor, 3, 1, randomWord());
    stopCommands();

    while (expectedData.size() != 0) @(negedge clock);
    repeat (2) @(negedge clock);
    $display("Checked %0d results, %0d errors", resultCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
logic/arrayPkg.sv
logic/decodedIf.sv
logic/executedIf.sv
logic/commandDecode.sv
logic/elementExecute.sv
logic/resultSelect.sv
logic/arrayMemory.sv
testbench/arrayMemoryAssertions.sv
testbench/arrayMemoryTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = arrayMemoryTb
FILELIST = list.f
OBJDIR   = obj_dir
PASSTEXT = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
